/* Bender.yml */
package:
  name: processor

sources:
  - source/proc_pkg.sv
  - source/ctrl_decoder.sv
  - source/fetch_stage.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/mem_wb_stage.sv
  - source/hazard_unit.sv
  - source/processor.sv
  - target: test
    files:
      - bench/tb_processor.sv

/* bench/tb_processor.sv */
// pipelined processor testbench
`timescale 1ns/1ps
`default_nettype none

module tb_processor;
    import proc_pkg::*;

    localparam word_t boot_addr  = 32'd0;
    localparam int    n_prog     = 4;
    localparam int    max_cycles = 200;   // per program
    localparam int    k_reg      = 0;     // expected register value
    localparam int    k_mem      = 1;     // expected data word
    localparam int    k_pre      = 2;     // data word loaded before the run

    logic     clock, rst;
    word_t    address_imem, q_imem, address_dmem, data, q_dmem;
    logic     wren, ctrl_write_enable;
    reg_idx_t ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;
    word_t    data_writeback, data_read_reg_a, data_read_reg_b;

    word_t imem [32];
    word_t dmem [64];
    word_t regs [32];

    // program table and its expected results
    word_t prog_mem [n_prog][32];
    word_t end_addr [n_prog];
    int    chk_prog [$];
    int    chk_kind [$];
    int    chk_idx  [$];
    word_t chk_val  [$];

    integer seed;
    int     errors;
    int     checks;
    int     p;

    processor #(.boot_addr(boot_addr)) i_dut (
        .clock             (clock),
        .rst               (rst),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_writeback    (data_writeback),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    // memories and register file answer in the same cycle
    assign q_imem          = imem[address_imem[4:0]];
    assign q_dmem          = dmem[address_dmem[5:0]];
    assign data_read_reg_a = regs[ctrl_read_reg_a];
    assign data_read_reg_b = regs[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (wren) begin
            dmem[address_dmem[5:0]] <= data;
        end
        if (ctrl_write_enable) begin
            regs[ctrl_write_reg] <= data_writeback;   // r0 not protected here
        end
    end

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic word_t alu_insn(input logic [4:0] fn, input reg_idx_t rd, rs, rt, sh);
        return {op_alu, rd, rs, rt, sh, fn, 2'b00};
    endfunction

    function automatic word_t imm_insn(input opcode_e op, input reg_idx_t rd, rs,
                                       input word_t imm);
        return {op, rd, rs, imm[16:0]};
    endfunction

    function automatic word_t jump_insn(input opcode_e op, input word_t target);
        return {op, target[26:0]};
    endfunction

    task automatic add_check(input int prog, kind, idx, input word_t val);
        chk_prog.push_back(prog);
        chk_kind.push_back(kind);
        chk_idx.push_back(idx);
        chk_val.push_back(val);
    endtask

    task automatic build_table();
        int i;
        int j;
        for (i = 0; i < n_prog; i++) begin
            for (j = 0; j < 32; j++) begin
                prog_mem[i][j] = nop_insn;
            end
        end
        // dependent alu chain
        prog_mem[0][0]  = imm_insn(op_addi, 1, 0, 12);
        prog_mem[0][1]  = imm_insn(op_addi, 2, 0, -5);
        prog_mem[0][2]  = alu_insn(alu_add, 3, 1, 2, 0);
        prog_mem[0][3]  = alu_insn(alu_sub, 4, 3, 1, 0);   // r1 via decode bypass
        prog_mem[0][4]  = alu_insn(alu_and, 5, 4, 1, 0);
        prog_mem[0][5]  = alu_insn(alu_or, 6, 5, 3, 0);
        prog_mem[0][6]  = alu_insn(alu_sll, 7, 6, 0, 4);
        prog_mem[0][7]  = alu_insn(alu_sra, 8, 4, 0, 1);
        prog_mem[0][8]  = imm_insn(op_addi, 9, 8, 100);
        prog_mem[0][9]  = alu_insn(alu_add, 10, 1, 9, 0);
        prog_mem[0][10] = imm_insn(op_addi, 0, 0, 77);
        prog_mem[0][11] = alu_insn(alu_add, 11, 0, 7, 0);
        prog_mem[0][12] = alu_insn(5'd6, 12, 1, 1, 0);   // mul code, no-op
        prog_mem[0][13] = jump_insn(op_j, 13);
        end_addr[0] = 13;
        add_check(0, k_reg, 1, 32'd12);
        add_check(0, k_reg, 2, 32'hffff_fffb);
        add_check(0, k_reg, 3, 32'd7);
        add_check(0, k_reg, 4, 32'hffff_fffb);
        add_check(0, k_reg, 5, 32'd8);
        add_check(0, k_reg, 6, 32'd15);
        add_check(0, k_reg, 7, 32'd240);
        add_check(0, k_reg, 8, 32'hffff_fffd);
        add_check(0, k_reg, 9, 32'd97);
        add_check(0, k_reg, 10, 32'd109);
        add_check(0, k_reg, 11, 32'd240);
        add_check(0, k_reg, 12, 32'd0);
        // loads, load-use stalls, store after load
        prog_mem[1][0] = imm_insn(op_addi, 1, 0, 20);
        prog_mem[1][1] = imm_insn(op_lw, 2, 1, 0);
        prog_mem[1][2] = alu_insn(alu_add, 3, 2, 2, 0);
        prog_mem[1][3] = imm_insn(op_lw, 4, 1, 1);
        prog_mem[1][4] = imm_insn(op_sw, 4, 1, 5);
        prog_mem[1][5] = alu_insn(alu_sra, 5, 4, 0, 1);
        prog_mem[1][6] = imm_insn(op_sw, 3, 1, 6);
        prog_mem[1][7] = imm_insn(op_lw, 6, 1, 6);
        prog_mem[1][8] = alu_insn(alu_sub, 7, 6, 2, 0);
        prog_mem[1][9] = jump_insn(op_j, 9);
        end_addr[1] = 9;
        add_check(1, k_pre, 20, 32'h1234_5678);
        add_check(1, k_pre, 21, 32'h8000_0003);
        add_check(1, k_reg, 1, 32'd20);
        add_check(1, k_reg, 2, 32'h1234_5678);
        add_check(1, k_reg, 3, 32'h2468_acf0);
        add_check(1, k_reg, 4, 32'h8000_0003);
        add_check(1, k_reg, 5, 32'hc000_0001);
        add_check(1, k_reg, 6, 32'h2468_acf0);
        add_check(1, k_reg, 7, 32'h1234_5678);
        add_check(1, k_mem, 20, 32'h1234_5678);
        add_check(1, k_mem, 25, 32'h8000_0003);
        add_check(1, k_mem, 26, 32'h2468_acf0);
        // taken and fall-through branches
        prog_mem[2][0]  = imm_insn(op_addi, 1, 0, 3);
        prog_mem[2][1]  = imm_insn(op_addi, 2, 0, -2);
        prog_mem[2][2]  = imm_insn(op_bne, 1, 2, 2);    // to 5
        prog_mem[2][3]  = imm_insn(op_addi, 3, 0, 111);
        prog_mem[2][4]  = imm_insn(op_addi, 4, 0, 222);
        prog_mem[2][5]  = imm_insn(op_blt, 2, 1, 1);    // -2 < 3, to 7
        prog_mem[2][6]  = imm_insn(op_addi, 5, 0, 333);
        prog_mem[2][7]  = imm_insn(op_blt, 1, 2, 1);
        prog_mem[2][8]  = imm_insn(op_addi, 6, 0, 44);
        prog_mem[2][9]  = imm_insn(op_bne, 1, 1, 1);
        prog_mem[2][10] = imm_insn(op_addi, 7, 0, 55);
        prog_mem[2][11] = jump_insn(op_j, 11);
        end_addr[2] = 11;
        add_check(2, k_reg, 1, 32'd3);
        add_check(2, k_reg, 2, 32'hffff_fffe);
        add_check(2, k_reg, 3, 32'd0);
        add_check(2, k_reg, 4, 32'd0);
        add_check(2, k_reg, 5, 32'd0);
        add_check(2, k_reg, 6, 32'd44);
        add_check(2, k_reg, 7, 32'd55);
        // jal into a routine past the end loop, jr back
        prog_mem[3][0] = imm_insn(op_addi, 1, 0, 5);
        prog_mem[3][1] = jump_insn(op_jal, 6);
        prog_mem[3][2] = imm_insn(op_addi, 2, 31, 0);
        prog_mem[3][3] = jump_insn(op_j, 5);
        prog_mem[3][4] = imm_insn(op_addi, 3, 0, 99);
        prog_mem[3][5] = jump_insn(op_j, 5);
        prog_mem[3][6] = imm_insn(op_addi, 4, 1, 7);
        prog_mem[3][7] = imm_insn(op_jr, 31, 0, 0);
        end_addr[3] = 5;
        add_check(3, k_reg, 1, 32'd5);
        add_check(3, k_reg, 2, 32'd2);
        add_check(3, k_reg, 3, 32'd0);
        add_check(3, k_reg, 4, 32'd12);
        add_check(3, k_reg, 31, 32'd2);
    endtask

    task automatic check_value(input string name, input word_t got, exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic load_program(input int prog);
        int i;
        for (i = 0; i < 32; i++) begin
            imem[i] = prog_mem[prog][i];
            regs[i] = '0;
        end
        for (i = 0; i < 64; i++) begin
            dmem[i] = $random(seed);
        end
        for (i = 0; i < chk_prog.size(); i++) begin
            if (chk_prog[i] == prog && chk_kind[i] == k_pre) begin
                dmem[chk_idx[i]] = chk_val[i];
            end
        end
    endtask

    task automatic check_reset_outputs();
        check_value("wren", word_t'(wren), 32'd0);
        check_value("ctrl_write_enable", word_t'(ctrl_write_enable), 32'd0);
        check_value("address_imem", address_imem, boot_addr);
    endtask

    task automatic compare_results(input int prog);
        int i;
        for (i = 0; i < chk_prog.size(); i++) begin
            if (chk_prog[i] == prog && chk_kind[i] == k_reg) begin
                check_value($sformatf("r%0d", chk_idx[i]), regs[chk_idx[i]], chk_val[i]);
            end else if (chk_prog[i] == prog && chk_kind[i] == k_mem) begin
                check_value($sformatf("dmem[%0d]", chk_idx[i]), dmem[chk_idx[i]], chk_val[i]);
            end
        end
        check_value("r0", regs[0], 32'd0);
    endtask

    task automatic run_program(input int prog);
        int cycles;
        @(posedge clock) rst <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        load_program(prog);
        check_reset_outputs();
        @(posedge clock) rst <= 1'b0;
        @(negedge clock);
        check_reset_outputs();   // first cycle out of reset
        cycles = 0;
        while (address_imem !== end_addr[prog] && cycles < max_cycles) begin
            @(negedge clock);
            cycles++;
        end
        if (address_imem !== end_addr[prog]) begin
            $display("Error: program %0d never reached its end loop at address %0d",
                     prog, end_addr[prog]);
            errors++;
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        compare_results(prog);
    endtask

    initial begin
        rst    = 1'b1;
        seed   = 30890;
        errors = 0;
        checks = 0;
        for (int i = 0; i < 32; i++) begin
            imem[i] = nop_insn;
            regs[i] = '0;
        end
        build_table();
        for (p = 0; p < n_prog; p++) begin
            run_program(p);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* source/ctrl_decoder.sv */
// instruction field and control decode
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder (
    input  proc_pkg::word_t    insn,
    output proc_pkg::opcode_e  opcode,
    output proc_pkg::alu_op_e  alu_op,
    output proc_pkg::reg_idx_t rd,
    output proc_pkg::reg_idx_t rs,
    output proc_pkg::reg_idx_t rt,
    output proc_pkg::reg_idx_t shamt,
    output proc_pkg::word_t    imm,
    output proc_pkg::word_t    target,
    output logic               reg_write, mem_write, mem_read, alu_imm,
    output logic               is_branch, is_jump, is_link, is_jr
);
    import proc_pkg::*;

    assign opcode = opcode_e'(insn[31:27]);
    assign rd     = insn[26:22];
    assign rs     = insn[21:17];
    assign rt     = insn[16:12];
    assign shamt  = insn[11:7];
    assign imm    = {{15{insn[16]}}, insn[16:0]};
    assign target = {5'b0, insn[26:0]};

    // addi, lw and sw reuse the adder
    assign alu_op = (opcode == op_alu) ? alu_op_e'(insn[6:2]) : alu_add;

    always_comb begin
        reg_write = 1'b0;
        mem_write = 1'b0;
        mem_read  = 1'b0;
        alu_imm   = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        is_link   = 1'b0;
        is_jr     = 1'b0;
        case (opcode)
            // mul, div and other unknown functions stay a no-op
            op_alu:  reg_write = alu_op inside {alu_add, alu_sub, alu_and,
                                                alu_or, alu_sll, alu_sra};
            op_addi: begin
                reg_write = 1'b1;
                alu_imm   = 1'b1;
            end
            op_lw: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                alu_imm   = 1'b1;
            end
            op_sw: begin
                mem_write = 1'b1;
                alu_imm   = 1'b1;
            end
            op_bne, op_blt: is_branch = 1'b1;
            op_j:    is_jump = 1'b1;
            op_jal: begin
                is_jump   = 1'b1;
                is_link   = 1'b1;
                reg_write = 1'b1;
            end
            op_jr: begin
                is_jump = 1'b1;
                is_jr   = 1'b1;
            end
            default: ;
        endcase
    end
endmodule

`default_nettype wire

/* source/decode_stage.sv */
// decode stage and D/X latch
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               clock,
    input  logic               rst,
    input  logic               stall,
    input  logic               redirect,
    input  proc_pkg::word_t    fd_pc,
    input  proc_pkg::word_t    fd_insn,
    input  proc_pkg::word_t    data_read_reg_a,
    input  proc_pkg::word_t    data_read_reg_b,
    input  proc_pkg::word_t    data_writeback,
    input  logic               dec_byp_a,
    input  logic               dec_byp_b,
    output proc_pkg::reg_idx_t ctrl_read_reg_a,
    output proc_pkg::reg_idx_t ctrl_read_reg_b,
    output logic               fd_is_store,
    output proc_pkg::word_t    dx_pc, dx_a, dx_b, dx_imm, dx_target,
    output proc_pkg::alu_op_e  dx_alu_op,
    output proc_pkg::reg_idx_t dx_shamt, dx_src_a, dx_src_b, dx_dest,
    output logic               dx_reg_write, dx_mem_write, dx_mem_read, dx_alu_imm,
    output logic               dx_is_branch, dx_is_jump, dx_is_link, dx_is_jr,
    output proc_pkg::opcode_e  dx_opcode
);
    import proc_pkg::*;

    opcode_e  opcode;
    alu_op_e  alu_op;
    reg_idx_t rd, rs, rt, shamt;
    word_t    imm, target;
    logic     reg_write, mem_write, mem_read, alu_imm;
    logic     is_branch, is_jump, is_link, is_jr;
    word_t    val_a, val_b;

    ctrl_decoder i_ctrl_decoder (.insn(fd_insn), .*);

    // branches compare rd with rs, jr jumps through rd
    assign ctrl_read_reg_a = (is_branch || is_jr) ? rd : rs;
    assign ctrl_read_reg_b = (mem_write || mem_read) ? rd : (is_branch ? rs : rt);
    assign fd_is_store     = mem_write;

    // a writeback in this same cycle is not yet on the read ports
    assign val_a = dec_byp_a ? data_writeback : data_read_reg_a;
    assign val_b = dec_byp_b ? data_writeback : data_read_reg_b;

    always_ff @(posedge clock) begin
        if (rst || stall || redirect) begin
            dx_src_a     <= '0;
            dx_src_b     <= '0;
            dx_dest      <= '0;
            dx_reg_write <= 1'b0;
            dx_mem_write <= 1'b0;
            dx_mem_read  <= 1'b0;
            dx_alu_imm   <= 1'b0;
            dx_is_branch <= 1'b0;
            dx_is_jump   <= 1'b0;
            dx_is_link   <= 1'b0;
            dx_is_jr     <= 1'b0;
        end else begin
            dx_src_a     <= is_link ? '0 : ctrl_read_reg_a;   // link value never forwarded
            dx_src_b     <= ctrl_read_reg_b;
            dx_dest      <= is_link ? link_reg : rd;
            dx_reg_write <= reg_write;
            dx_mem_write <= mem_write;
            dx_mem_read  <= mem_read;
            dx_alu_imm   <= alu_imm;
            dx_is_branch <= is_branch;
            dx_is_jump   <= is_jump;
            dx_is_link   <= is_link;
            dx_is_jr     <= is_jr;
        end
    end

    always_ff @(posedge clock) begin
        dx_pc     <= fd_pc;
        dx_a      <= is_link ? fd_pc : val_a;   // fd_pc is already pc+1
        dx_b      <= val_b;
        dx_imm    <= imm;
        dx_target <= target;
        dx_alu_op <= alu_op;
        dx_shamt  <= shamt;
        dx_opcode <= opcode;
    end
endmodule

`default_nettype wire

/* source/execute_stage.sv */
// execute stage and X/M latch
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic               clock,
    input  logic               rst,
    input  proc_pkg::word_t    dx_pc, dx_a, dx_b, dx_imm, dx_target,
    input  proc_pkg::alu_op_e  dx_alu_op,
    input  proc_pkg::reg_idx_t dx_shamt, dx_dest,
    input  logic               dx_reg_write, dx_mem_write, dx_mem_read, dx_alu_imm,
    input  logic               dx_is_branch, dx_is_jump, dx_is_link, dx_is_jr,
    input  proc_pkg::opcode_e  dx_opcode,
    input  proc_pkg::fwd_sel_e fwd_a, fwd_b,
    input  proc_pkg::word_t    data_writeback,
    output logic               redirect,
    output proc_pkg::word_t    redirect_pc,
    output proc_pkg::word_t    xm_result, xm_store,
    output proc_pkg::reg_idx_t xm_dest,
    output logic               xm_reg_write, xm_mem_write, xm_mem_read
);
    import proc_pkg::*;

    word_t op_a, op_b, alu_b, alu_out;
    logic  taken;

    function automatic word_t pick(fwd_sel_e sel, word_t latched, word_t mem_val,
                                   word_t wb_val);
        word_t v;
        case (sel)
            fwd_mem: v = mem_val;
            fwd_wb:  v = wb_val;
            default: v = latched;
        endcase
        return v;
    endfunction

    assign op_a  = pick(fwd_a, dx_a, xm_result, data_writeback);
    assign op_b  = pick(fwd_b, dx_b, xm_result, data_writeback);
    assign alu_b = dx_alu_imm ? dx_imm : op_b;   // addi, lw, sw

    always_comb begin
        case (dx_alu_op)
            alu_add: alu_out = op_a + alu_b;
            alu_sub: alu_out = op_a - alu_b;
            alu_and: alu_out = op_a & alu_b;
            alu_or:  alu_out = op_a | alu_b;
            alu_sll: alu_out = op_a << dx_shamt;
            alu_sra: alu_out = word_t'($signed(op_a) >>> dx_shamt);
            default: alu_out = '0;
        endcase
    end

    // A carries rd and B carries rs for both branches
    always_comb begin
        case (dx_opcode)
            op_bne:  taken = op_a != op_b;
            op_blt:  taken = $signed(op_a) < $signed(op_b);
            default: taken = 1'b0;
        endcase
    end

    assign redirect = dx_is_jump || (dx_is_branch && taken);

    always_comb begin
        if (dx_is_branch) begin
            redirect_pc = dx_pc + dx_imm;
        end else if (dx_is_jr) begin
            redirect_pc = op_a;
        end else begin
            redirect_pc = dx_target;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            xm_reg_write <= 1'b0;
            xm_mem_write <= 1'b0;
            xm_mem_read  <= 1'b0;
        end else begin
            xm_reg_write <= dx_reg_write;
            xm_mem_write <= dx_mem_write;
            xm_mem_read  <= dx_mem_read;
        end
    end

    always_ff @(posedge clock) begin
        xm_result <= dx_is_link ? dx_a : alu_out;
        xm_store  <= op_b;
        xm_dest   <= dx_dest;   // store data register for sw
    end

    // load-use stall keeps a load in X/M from feeding operand A
    no_load_fwd: assert property (@(posedge clock) disable iff (rst)
        xm_mem_read |-> fwd_a != fwd_mem);
endmodule

`default_nettype wire

/* source/fetch_stage.sv */
// instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter proc_pkg::word_t boot_addr = '0
) (
    input  logic            clock,
    input  logic            rst,
    input  logic            stall,
    input  logic            redirect,
    input  proc_pkg::word_t redirect_pc,
    input  proc_pkg::word_t q_imem,
    output proc_pkg::word_t address_imem,
    output proc_pkg::word_t fd_pc,
    output proc_pkg::word_t fd_insn
);
    import proc_pkg::*;

    word_t pc;
    word_t pc_plus1;

    assign pc_plus1     = pc + 32'd1;
    assign address_imem = pc;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc      <= boot_addr;
            fd_insn <= nop_insn;
        end else if (redirect) begin
            pc      <= redirect_pc;
            fd_insn <= nop_insn;   // squash wrong-path fetch
        end else if (!stall) begin
            pc      <= pc_plus1;
            fd_insn <= q_imem;
        end
    end

    // base for branches and the jal link value
    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc <= pc_plus1;
        end
    end

    // a load in D/X is never also a jump or branch
    not_both: assert property (@(posedge clock) disable iff (rst)
        !(redirect && stall));
endmodule

`default_nettype wire

/* source/hazard_unit.sv */
// forwarding and stall detection
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  proc_pkg::reg_idx_t read_reg_a, read_reg_b,
    input  logic               fd_is_store,
    input  proc_pkg::reg_idx_t dx_src_a, dx_src_b, dx_dest,
    input  logic               dx_mem_read,
    input  proc_pkg::reg_idx_t xm_dest,
    input  logic               xm_reg_write, xm_mem_write,
    input  proc_pkg::reg_idx_t xm_store_src,
    input  proc_pkg::reg_idx_t ctrl_write_reg,
    input  logic               ctrl_write_enable,
    output logic               stall,
    output proc_pkg::fwd_sel_e fwd_a, fwd_b,
    output logic               dec_byp_a, dec_byp_b, store_fwd
);
    import proc_pkg::*;

    logic xm_live;   // X/M writes a real register

    assign xm_live = xm_reg_write && (xm_dest != '0);

    // newer X/M result wins over M/W
    assign fwd_a = (xm_live && xm_dest == dx_src_a) ? fwd_mem :
                   (ctrl_write_enable && ctrl_write_reg == dx_src_a) ? fwd_wb :
                   fwd_none;
    assign fwd_b = (xm_live && xm_dest == dx_src_b) ? fwd_mem :
                   (ctrl_write_enable && ctrl_write_reg == dx_src_b) ? fwd_wb :
                   fwd_none;

    // register file write and read in the same cycle
    assign dec_byp_a = ctrl_write_enable && ctrl_write_reg == read_reg_a;
    assign dec_byp_b = ctrl_write_enable && ctrl_write_reg == read_reg_b;

    // load data arrives in M/W while the store sits in X/M
    assign store_fwd = xm_mem_write && ctrl_write_enable && ctrl_write_reg == xm_store_src;

    // store data is covered by store_fwd, so no stall for port B of sw
    assign stall = dx_mem_read && (dx_dest != '0) &&
                   (dx_dest == read_reg_a || (!fd_is_store && dx_dest == read_reg_b));
endmodule

`default_nettype wire

/* source/mem_wb_stage.sv */
// memory access and writeback
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  logic               clock,
    input  logic               rst,
    input  proc_pkg::word_t    xm_result, xm_store,
    input  proc_pkg::reg_idx_t xm_dest,
    input  logic               xm_reg_write, xm_mem_write, xm_mem_read,
    input  logic               store_fwd,
    input  proc_pkg::word_t    q_dmem,
    output proc_pkg::word_t    address_dmem,
    output proc_pkg::word_t    data,
    output logic               wren,
    output logic               ctrl_write_enable,
    output proc_pkg::reg_idx_t ctrl_write_reg,
    output proc_pkg::word_t    data_writeback
);
    import proc_pkg::*;

    word_t    mw_result, mw_load;
    reg_idx_t mw_dest;
    logic     mw_reg_write, mw_mem_read;

    assign address_dmem = xm_result;
    assign data         = store_fwd ? data_writeback : xm_store;   // lw right before sw
    assign wren         = xm_mem_write;

    always_ff @(posedge clock) begin
        if (rst) begin
            mw_reg_write <= 1'b0;
            mw_mem_read  <= 1'b0;
        end else begin
            mw_reg_write <= xm_reg_write;
            mw_mem_read  <= xm_mem_read;
        end
    end

    always_ff @(posedge clock) begin
        mw_result <= xm_result;
        mw_load   <= q_dmem;
        mw_dest   <= xm_dest;
    end

    // r0 stays zero
    assign ctrl_write_enable = mw_reg_write && (mw_dest != '0);
    assign ctrl_write_reg    = mw_dest;
    assign data_writeback    = mw_mem_read ? mw_load : mw_result;

    // a store's dest is its data register and must not be written
    store_no_wb: assert property (@(posedge clock) disable iff (rst)
        wren |-> !xm_reg_write);
endmodule

`default_nettype wire

/* source/proc_pkg.sv */
// processor shared definitions
`default_nettype none

package proc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcode in insn[31:27]
    typedef enum logic [4:0] {
        op_alu  = 5'd0,
        op_j    = 5'd1,
        op_bne  = 5'd2,
        op_jal  = 5'd3,
        op_jr   = 5'd4,
        op_addi = 5'd5,
        op_blt  = 5'd6,
        op_sw   = 5'd7,
        op_lw   = 5'd8
    } opcode_e;

    // function field of alu-format words, insn[6:2]
    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    // operand source in execute
    typedef enum logic [1:0] {
        fwd_none = 2'd0,   // value latched in D/X
        fwd_mem  = 2'd1,   // X/M result
        fwd_wb   = 2'd2    // writeback data
    } fwd_sel_e;

    localparam reg_idx_t link_reg = 5'd31;   // jal return address
    localparam word_t    nop_insn = 32'h0000_0000;   // add r0, r0, r0

endpackage

`default_nettype wire

/* source/processor.sv */
// five-stage pipelined processor
`timescale 1ns/1ps
`default_nettype none

module processor #(
    parameter proc_pkg::word_t boot_addr = '0
) (
    input  logic               clock,
    input  logic               rst,
    output proc_pkg::word_t    address_imem,
    input  proc_pkg::word_t    q_imem,
    output proc_pkg::word_t    address_dmem,
    output proc_pkg::word_t    data,
    output logic               wren,
    input  proc_pkg::word_t    q_dmem,
    output logic               ctrl_write_enable,
    output proc_pkg::reg_idx_t ctrl_write_reg,
    output proc_pkg::reg_idx_t ctrl_read_reg_a,
    output proc_pkg::reg_idx_t ctrl_read_reg_b,
    output proc_pkg::word_t    data_writeback,
    input  proc_pkg::word_t    data_read_reg_a,
    input  proc_pkg::word_t    data_read_reg_b
);
    import proc_pkg::*;

    // F/D latch
    word_t    fd_pc, fd_insn;
    logic     fd_is_store;

    // D/X latch
    word_t    dx_pc, dx_a, dx_b, dx_imm, dx_target;
    alu_op_e  dx_alu_op;
    reg_idx_t dx_shamt, dx_src_a, dx_src_b, dx_dest;
    logic     dx_reg_write, dx_mem_write, dx_mem_read, dx_alu_imm;
    logic     dx_is_branch, dx_is_jump, dx_is_link, dx_is_jr;
    opcode_e  dx_opcode;

    // X/M latch
    word_t    xm_result, xm_store;
    reg_idx_t xm_dest;
    logic     xm_reg_write, xm_mem_write, xm_mem_read;

    // hazard and redirect control
    logic     stall, redirect;
    word_t    redirect_pc;
    fwd_sel_e fwd_a, fwd_b;
    logic     dec_byp_a, dec_byp_b, store_fwd;

    fetch_stage #(.boot_addr(boot_addr)) i_fetch_stage (.*);

    decode_stage i_decode_stage (.*);

    execute_stage i_execute_stage (.*);

    mem_wb_stage i_mem_wb_stage (.*);

    hazard_unit i_hazard_unit (
        .read_reg_a   (ctrl_read_reg_a),
        .read_reg_b   (ctrl_read_reg_b),
        .xm_store_src (xm_dest),   // sw carries its data register as dest
        .*
    );
endmodule

`default_nettype wire

/* sources.f */
source/proc_pkg.sv
source/ctrl_decoder.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/hazard_unit.sv
source/processor.sv
bench/tb_processor.sv
